// ==== all.f ====
rtl/float_pkg.sv
rtl/float_normalize.sv
rtl/float_add_pipeline.sv
rtl/float_accum_ctrl.sv
rtl/float_accum_top.sv
verification/float_accum_checker.sv
verification/tb_float_accum.sv

// ==== rtl/float_accum_ctrl.sv ====
/*
 * Host-side controller for the float accumulator.
 * Runs the four-phase host handshake, holds the accumulator and sends adds
 * to the adder with a one-cycle request pulse.
 */
`timescale 1ns/100ps
`default_nettype none

module float_accum_ctrl (
    input  wire  clk,
    input  wire  rst,
    input  wire  req,
    input  wire  float_pkg::accum_cmd_t  cmd,
    output logic ack,
    output float_pkg::float_word_t       result,
    output logic add_req,
    output float_pkg::float_word_t       add_a,
    output float_pkg::float_word_t       add_b,
    input  wire  add_ack,
    input  wire  float_pkg::float_word_t add_sum
);

    typedef enum logic [1:0] {
        st_wait_req,
        st_issue,
        st_wait_add,
        st_hold_ack
    } state_t;

    state_t                 state;
    float_pkg::accum_cmd_t  cmd_r;
    float_pkg::float_word_t acc;

    // new command only once the previous ack has dropped
    logic take_cmd;
    assign take_cmd = (state == st_wait_req) && req && !ack;

    // command captured once per transaction
    always_ff @(posedge clk) begin
        if (take_cmd) begin
            cmd_r <= cmd;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= st_wait_req;
            ack     <= 1'b0;
            add_req <= 1'b0;
            acc     <= '0;
        end else begin
            // request is a single-cycle pulse
            add_req <= 1'b0;
            case (state)
                st_wait_req: begin
                    if (take_cmd) begin
                        state <= st_issue;
                    end
                end
                st_issue: begin
                    if (cmd_r.op == float_pkg::op_load) begin
                        acc   <= cmd_r.operand;
                        ack   <= 1'b1;
                        state <= st_hold_ack;
                    end else begin
                        add_req <= 1'b1;
                        state   <= st_wait_add;
                    end
                end
                st_wait_add: begin
                    if (add_ack) begin
                        acc   <= add_sum;
                        ack   <= 1'b1;
                        state <= st_hold_ack;
                    end
                end
                st_hold_ack: begin
                    // host drops req, then ack follows one edge later
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= st_wait_req;
                    end
                end
                default: begin
                    state <= st_wait_req;
                end
            endcase
        end
    end

    // accumulator is frozen while ack is high
    assign result = acc;
    assign add_a  = acc;
    assign add_b  = cmd_r.operand;

endmodule

`default_nettype wire

// ==== rtl/float_accum_top.sv ====
/*
 * Top level of the float accumulate unit.
 * Joins the host controller to the multicycle adder.
 */
`timescale 1ns/100ps
`default_nettype none

module float_accum_top (
    input  wire  clk,
    input  wire  rst,
    input  wire  req,
    input  wire  float_pkg::accum_cmd_t cmd,
    output logic ack,
    output float_pkg::float_word_t      result
);

    // controller to adder
    logic                   add_req;
    float_pkg::float_word_t add_a;
    float_pkg::float_word_t add_b;

    // adder back to controller
    logic                   add_ack;
    float_pkg::float_word_t add_sum;

    float_accum_ctrl u_ctrl (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .cmd     (cmd),
        .ack     (ack),
        .result  (result),
        .add_req (add_req),
        .add_a   (add_a),
        .add_b   (add_b),
        .add_ack (add_ack),
        .add_sum (add_sum)
    );

    // accumulator goes in as a, operand as b
    float_add_pipeline u_adder (
        .clk (clk),
        .rst (rst),
        .req (add_req),
        .a   (add_a),
        .b   (add_b),
        .sum (add_sum),
        .ack (add_ack)
    );

endmodule

`default_nettype wire

// ==== rtl/float_add_pipeline.sv ====
/*
 * Multicycle float adder with a pulse handshake.
 * A one-cycle req starts an add; sum and a one-cycle ack are registered two
 * edges after the edge that takes req, and sum reads zero at every other time.
 */
`timescale 1ns/100ps
`default_nettype none

module float_add_pipeline (
    input  wire  clk,
    input  wire  rst,
    input  wire  req,
    input  wire  float_pkg::float_word_t a,
    input  wire  float_pkg::float_word_t b,
    output float_pkg::float_word_t       sum,
    output logic ack
);

    typedef enum logic [1:0] {
        st_idle,
        st_combine,
        st_normalize
    } state_t;

    state_t state;
    state_t n_state;

    // aligned operands
    logic                                  a_sign;
    logic                                  b_sign;
    float_pkg::wide_mant_t                 a_mant;
    float_pkg::wide_mant_t                 b_mant;
    logic [float_pkg::float_exp_width-1:0] exp_r;

    // combined result before normalization
    logic                                  new_sign;
    float_pkg::wide_mant_t                 new_mant;

    logic                                  n_a_sign;
    logic                                  n_b_sign;
    float_pkg::wide_mant_t                 n_a_mant;
    float_pkg::wide_mant_t                 n_b_mant;
    logic [float_pkg::float_exp_width-1:0] n_exp;
    logic                                  n_new_sign;
    float_pkg::wide_mant_t                 n_new_mant;
    float_pkg::float_word_t                n_sum;
    logic                                  n_ack;

    // normalizer output
    float_pkg::wide_mant_t                 norm_mant;
    logic [float_pkg::float_exp_width-1:0] norm_exp;

    float_normalize u_normalize (
        .mant_in  (new_mant),
        .exp_in   (exp_r),
        .mant_out (norm_mant),
        .exp_out  (norm_exp)
    );

    always_comb begin
        n_state    = state;
        n_a_sign   = a_sign;
        n_b_sign   = b_sign;
        n_a_mant   = a_mant;
        n_b_mant   = b_mant;
        n_exp      = exp_r;
        n_new_sign = new_sign;
        n_new_mant = new_mant;
        n_sum      = '0;
        n_ack      = 1'b0;

        case (state)
            st_idle: begin
                if (req) begin
                    // implicit one is always set even for a zero exponent
                    n_a_sign = a.fields.sign;
                    n_b_sign = b.fields.sign;
                    n_a_mant = {3'b001, a.fields.mant};
                    n_b_mant = {3'b001, b.fields.mant};
                    // align the smaller exponent
                    // shifted-out bits are lost
                    if (a.fields.exp > b.fields.exp) begin
                        n_exp    = a.fields.exp;
                        n_b_mant = n_b_mant >> (a.fields.exp - b.fields.exp);
                    end else begin
                        n_exp    = b.fields.exp;
                        n_a_mant = n_a_mant >> (b.fields.exp - a.fields.exp);
                    end
                    n_state = st_combine;
                end
            end
            st_combine: begin
                if (a_sign != b_sign) begin
                    // larger magnitude keeps its sign
                    // a tie goes to b
                    if (a_mant > b_mant) begin
                        n_new_mant = a_mant - b_mant;
                        n_new_sign = a_sign;
                    end else begin
                        n_new_mant = b_mant - a_mant;
                        n_new_sign = b_sign;
                    end
                end else begin
                    n_new_mant = a_mant + b_mant;
                    n_new_sign = a_sign;
                end
                n_state = st_normalize;
            end
            st_normalize: begin
                // a zero result never carries a sign
                n_sum.fields.sign = (norm_mant == '0) ? 1'b0 : new_sign;
                n_sum.fields.exp  = norm_exp;
                n_sum.fields.mant = norm_mant[float_pkg::float_mant_width-1:0];
                n_ack             = 1'b1;
                n_state           = st_idle;
            end
            default: begin
                n_state = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= st_idle;
            sum      <= '0;
            ack      <= 1'b0;
            a_sign   <= 1'b0;
            b_sign   <= 1'b0;
            a_mant   <= '0;
            b_mant   <= '0;
            exp_r    <= '0;
            new_sign <= 1'b0;
            new_mant <= '0;
        end else begin
            state    <= n_state;
            sum      <= n_sum;
            ack      <= n_ack;
            a_sign   <= n_a_sign;
            b_sign   <= n_b_sign;
            a_mant   <= n_a_mant;
            b_mant   <= n_b_mant;
            exp_r    <= n_exp;
            new_sign <= n_new_sign;
            new_mant <= n_new_mant;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/float_normalize.sv ====
/*
 * Combinational normalizer for a raw sum mantissa.
 * Folds a carry back, clears a zero result and moves the leading one to the
 * implicit position, adjusting the exponent to match.
 */
`timescale 1ns/100ps
`default_nettype none

module float_normalize (
    input  wire  float_pkg::wide_mant_t                 mant_in,
    input  wire  [float_pkg::float_exp_width-1:0]       exp_in,
    output float_pkg::wide_mant_t                       mant_out,
    output logic [float_pkg::float_exp_width-1:0]       exp_out
);

    // zero padding to widen the shift count to exponent width
    localparam int pad_width = float_pkg::float_exp_width - float_pkg::norm_shift_width;

    always_comb begin
        float_pkg::wide_mant_t                   m;
        logic [float_pkg::float_exp_width-1:0]   e;
        logic [float_pkg::norm_shift_width-1:0]  shift;

        m     = mant_in;
        e     = exp_in;
        shift = '0;

        // carry out of the implicit position
        // shift right once and bump the exponent
        if (m[float_pkg::float_mant_width+1]) begin
            m = m >> 1;
            e = e + 1'b1;
        end

        if (m == '0) begin
            // exact cancellation gives the all-zero word
            e = '0;
        end else begin
            // scan from the largest shift down
            // so the highest set bit wins last
            for (int i = float_pkg::float_mant_width; i >= 0; i--) begin
                if (m[float_pkg::float_mant_width - i]) begin
                    shift = i[float_pkg::norm_shift_width-1:0];
                end
            end
            // leading one lands on the implicit bit
            m = m << shift;
            e = e - {{pad_width{1'b0}}, shift};
        end

        mant_out = m;
        exp_out  = e;
    end

endmodule

`default_nettype wire

// ==== rtl/float_pkg.sv ====
/*
 * Shared definitions for the 16-bit float accumulate unit.
 * Holds the format widths, the float word views and the host command layout.
 */
`default_nettype none

package float_pkg;

    // format widths
    localparam int float_width      = 16;
    localparam int float_exp_width  = 5;
    localparam int float_mant_width = 10;

    // left-shift count for normalization, covers 0 to float_mant_width
    localparam int norm_shift_width = 4;

    // decoded view of a float word
    typedef struct packed {
        logic                        sign;
        logic [float_exp_width-1:0]  exp;
        logic [float_mant_width-1:0] mant;
    } float_fields_t;

    // one word seen either as raw bits or as its fields
    typedef union packed {
        logic [float_width-1:0] bits;
        float_fields_t          fields;
    } float_word_t;

    // host opcodes
    typedef enum logic {
        op_load = 1'b0,
        op_add  = 1'b1
    } accum_op_t;

    // one host command
    typedef struct packed {
        accum_op_t   op;
        float_word_t operand;
    } accum_cmd_t;

    // working mantissa, spare bit, carry bit, implicit one, stored bits
    typedef logic [float_mant_width+2:0] wide_mant_t;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the float accumulator testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -Wno-fatal \
    --top-module tb_float_accum \
    -Mdir "$build_dir" \
    -f all.f

"./$build_dir/Vtb_float_accum" | tee "$log_file"

if grep -q '\*\*\* FAILED \*\*\*' "$log_file"; then
    echo "simulation failed, see $log_file"
    exit 1
fi

echo "simulation passed"
exit 0

// ==== verification/float_accum_checker.sv ====
/*
 * Watches the host port of the float accumulate unit and checks every result
 * against a model of the truncating add rule, plus the four-phase protocol.
 * Samples on the falling clock edge where all host signals are stable.
 */
`timescale 1ns/100ps
`default_nettype none

module float_accum_checker (
    input  wire  clk,
    input  wire  rst,
    input  wire  req,
    input  wire  float_pkg::accum_cmd_t  cmd,
    input  wire  ack,
    input  wire  float_pkg::float_word_t result,
    input  wire  expect_on,
    input  wire  float_pkg::float_word_t expect_word,
    output float_pkg::float_word_t       model_acc,
    output int   test_count,
    output int   fail_count,
    output int   proto_errors
);

    logic                   req_prev;
    logic                   ack_prev;
    logic                   pending;
    float_pkg::accum_cmd_t  cmd_seen;
    float_pkg::float_word_t held;

    // reference add worked in plain integers
    function automatic float_pkg::float_word_t expected_sum(
        input float_pkg::float_word_t a,
        input float_pkg::float_word_t b
    );
        float_pkg::float_word_t res;
        int ma;
        int mb;
        int e;
        int m;
        logic s;
        // implicit one on both operands whatever the exponent
        ma = 1024 + int'(a.fields.mant);
        mb = 1024 + int'(b.fields.mant);
        // align the smaller exponent
        // dropped bits are gone
        if (a.fields.exp >= b.fields.exp) begin
            e  = int'(a.fields.exp);
            mb = mb >> (a.fields.exp - b.fields.exp);
        end else begin
            e  = int'(b.fields.exp);
            ma = ma >> (b.fields.exp - a.fields.exp);
        end
        if (a.fields.sign == b.fields.sign) begin
            m = ma + mb;
            s = a.fields.sign;
        end else if (ma > mb) begin
            m = ma - mb;
            s = a.fields.sign;
        end else begin
            // equal magnitudes take the sign of b
            m = mb - ma;
            s = b.fields.sign;
        end
        if (m >= 2048) begin
            m = m / 2;
            e = e + 1;
        end
        res = '0;
        if (m != 0) begin
            while (m < 1024) begin
                m = m * 2;
                e = e - 1;
            end
            res.fields.sign = s;
            res.fields.exp  = e[float_pkg::float_exp_width-1:0];
            res.fields.mant = m[float_pkg::float_mant_width-1:0];
        end
        return res;
    endfunction

    always @(negedge clk) begin
        float_pkg::float_word_t want;
        logic                   bad;
        if (!rst) begin
            req_prev     <= 1'b0;
            ack_prev     <= 1'b0;
            pending      <= 1'b0;
            model_acc    <= '0;
            held         <= '0;
            test_count   <= 0;
            fail_count   <= 0;
            proto_errors <= 0;
        end else begin
            want = '0;
            bad  = 1'b0;
            // new transaction when req rises with ack low
            if (req && !req_prev && !ack) begin
                cmd_seen <= cmd;
                pending  <= 1'b1;
            end
            if (ack && !ack_prev) begin
                if (!req || !pending) begin
                    $display("ack rose at %0t with no host request waiting for it", $time);
                    proto_errors <= proto_errors + 1;
                end else begin
                    if (cmd_seen.op == float_pkg::op_load) begin
                        want = cmd_seen.operand;
                    end else begin
                        want = expected_sum(model_acc, cmd_seen.operand);
                    end
                    bad = (result != want) || (expect_on && (result != expect_word));
                    if (bad) begin
                        $display("FAILED at %0t: test %0d %s %h gave %h, model %h, table %h",
                                 $time, test_count,
                                 (cmd_seen.op == float_pkg::op_load) ? "load" : "add",
                                 cmd_seen.operand.bits, result.bits, want.bits,
                                 expect_word.bits);
                        fail_count <= fail_count + 1;
                    end else begin
                        $display("test %0d %s %h -> %h ok", test_count,
                                 (cmd_seen.op == float_pkg::op_load) ? "load" : "add",
                                 cmd_seen.operand.bits, result.bits);
                    end
                    // model follows its own value and never the DUT's
                    model_acc  <= want;
                    test_count <= test_count + 1;
                end
                pending <= 1'b0;
            end
            // ack must stay up until the host has dropped req
            if (!ack && ack_prev && req) begin
                $display("ack fell at %0t while the host still held req", $time);
                proto_errors <= proto_errors + 1;
            end
            // result must not move while ack is up
            if (ack && ack_prev && (result != held)) begin
                $display("result changed from %h to %h at %0t while ack was high",
                         held.bits, result.bits, $time);
                proto_errors <= proto_errors + 1;
            end
            held     <= result;
            req_prev <= req;
            ack_prev <= ack;
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_float_accum.sv ====
/*
 * Testbench for the float accumulate unit.
 * Runs a hand-worked command table and then a seeded random phase through
 * the four-phase host port; the checker module judges every result.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_float_accum;

    localparam int table_len       = 14;
    localparam int random_count    = 40;
    localparam int cycles_per_test = 20;
    localparam int reset_cycles    = 8;
    localparam int watchdog_cycles =
        (table_len + random_count) * cycles_per_test + reset_cycles;

    // one table row, hold is extra cycles req stays up after ack
    typedef struct packed {
        float_pkg::accum_op_t op;
        logic [15:0]          operand;
        logic [15:0]          expected;
        logic [3:0]           hold;
    } stim_entry_t;

    logic                   clk;
    logic                   rst;
    logic                   req;
    float_pkg::accum_cmd_t  cmd;
    logic                   ack;
    float_pkg::float_word_t result;
    logic                   expect_on;
    float_pkg::float_word_t expect_word;
    float_pkg::float_word_t model_acc;
    int                     test_count;
    int                     fail_count;
    int                     proto_errors;
    int                     issued;
    int                     seed;
    stim_entry_t            stim_table [table_len];

    float_accum_top dut (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .cmd    (cmd),
        .ack    (ack),
        .result (result)
    );

    float_accum_checker u_checker (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .cmd          (cmd),
        .ack          (ack),
        .result       (result),
        .expect_on    (expect_on),
        .expect_word  (expect_word),
        .model_acc    (model_acc),
        .test_count   (test_count),
        .fail_count   (fail_count),
        .proto_errors (proto_errors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // one full four-phase cycle, drive on rising edges, sample on falling
    task automatic host_cycle(input float_pkg::accum_op_t op, input logic [15:0] operand,
                              input logic check_table, input logic [15:0] expected,
                              input int hold);
        float_pkg::accum_cmd_t c;
        c.op           = op;
        c.operand.bits = operand;
        @(posedge clk);
        req              <= 1'b1;
        cmd              <= c;
        expect_on        <= check_table;
        expect_word.bits <= expected;
        @(negedge clk);
        while (!ack) @(negedge clk);
        repeat (hold) @(negedge clk);
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        while (ack) @(negedge clk);
        issued++;
    endtask

    task automatic fill_table;
        // load, then truncating align, then a carry
        stim_table[0]  = '{float_pkg::op_load, 16'h3E00, 16'h3E00, 4'd4};
        stim_table[1]  = '{float_pkg::op_add,  16'h3007, 16'h3E80, 4'd0};
        stim_table[2]  = '{float_pkg::op_add,  16'h3F00, 16'h42C0, 4'd0};
        // larger negative operand wins the sign, then near cancellation
        stim_table[3]  = '{float_pkg::op_add,  16'hC400, 16'hB900, 4'd0};
        stim_table[4]  = '{float_pkg::op_add,  16'h38FF, 16'h9000, 4'd0};
        // exact negation clears the word, zero still has its implicit one
        stim_table[5]  = '{float_pkg::op_load, 16'h4A40, 16'h4A40, 4'd0};
        stim_table[6]  = '{float_pkg::op_add,  16'hCA40, 16'h0000, 4'd0};
        stim_table[7]  = '{float_pkg::op_add,  16'h0C00, 16'h0C80, 4'd0};
        // back-to-back chain of ones
        stim_table[8]  = '{float_pkg::op_load, 16'h3C00, 16'h3C00, 4'd0};
        stim_table[9]  = '{float_pkg::op_add,  16'h3C00, 16'h4000, 4'd0};
        stim_table[10] = '{float_pkg::op_add,  16'h3C00, 16'h4200, 4'd0};
        stim_table[11] = '{float_pkg::op_add,  16'h3C00, 16'h4400, 4'd0};
        stim_table[12] = '{float_pkg::op_add,  16'h3C00, 16'h4500, 4'd0};
        stim_table[13] = '{float_pkg::op_add,  16'hBC00, 16'h4400, 4'd0};
    endtask

    task automatic random_phase;
        logic [31:0]          r;
        logic [15:0]          operand;
        int                   span;
        int                   k;
        float_pkg::accum_op_t op;
        for (k = 0; k < random_count; k++) begin
            r       = $random(seed);
            span    = int'(r[7:0]) % 15;
            // exponent kept in 8 to 22
            operand = {r[31], 5'(8 + span), r[17:8]};
            op      = (r[30] | r[29]) ? float_pkg::op_add : float_pkg::op_load;
            if (k == 0) begin
                op = float_pkg::op_load;
            end else if (model_acc.fields.exp < 5'd4 || model_acc.fields.exp > 5'd26) begin
                // pull the accumulator back to a mid-range value
                host_cycle(float_pkg::op_load, {1'b0, 5'd15, r[27:18]}, 1'b0, 16'h0000, 0);
            end
            host_cycle(op, operand, 1'b0, 16'h0000, 0);
        end
    endtask

    initial begin
        int i;
        seed        = 74412;
        issued      = 0;
        rst         = 1'b0;
        req         = 1'b0;
        cmd         = '0;
        expect_on   = 1'b0;
        expect_word = '0;
        fill_table();
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b1;
        for (i = 0; i < table_len; i++) begin
            host_cycle(stim_table[i].op, stim_table[i].operand, 1'b1,
                       stim_table[i].expected, int'(stim_table[i].hold));
        end
        random_phase();
        repeat (4) @(posedge clk);
        $display("tests %0d sent %0d failed %0d protocol errors %0d",
                 test_count, issued, fail_count, proto_errors);
        if (fail_count == 0 && proto_errors == 0 && test_count == issued) begin
            $display("*** PASSED ***");
        end else begin
            if (test_count != issued) begin
                $display("the checker saw %0d results for %0d commands", test_count, issued);
            end
            $display("*** FAILED ***");
        end
        $finish;
    end

    // run-length bound from the number of tests
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the unit stopped answering the host",
                 watchdog_cycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
